// ==== hw/rvIsaPkg.sv ====
`default_nettype none

package rvIsaPkg;

	localparam int xlen = 32; // Data and address width
	localparam int regAddrW = 5;

	// Major opcodes of the supported subset
	typedef enum logic [6:0] {
		rType  = 7'b0110011,
		iType  = 7'b0010011, // ALU with immediate operand
		lwType = 7'b0000011,
		sType  = 7'b0100011,
		bType  = 7'b1100011,
		jType  = 7'b1101111  // jal
	} opcodeT;

	// funct3 values of the ALU instructions
	localparam logic [2:0] f3AddSub = 3'b000;
	localparam logic [2:0] f3Slt = 3'b010;
	localparam logic [2:0] f3Or = 3'b110;
	localparam logic [2:0] f3And = 3'b111;

	typedef enum logic [2:0] {
		aluAdd = 3'b000,
		aluSub = 3'b001,
		aluAnd = 3'b010,
		aluOr  = 3'b011,
		aluSlt = 3'b101
	} aluOpT;

	// Op class requested by the FSM
	typedef enum logic [1:0] {
		classAdd   = 2'b00,
		classSub   = 2'b01,
		classFunct = 2'b10
	} aluClassT;

endpackage

`default_nettype wire

// ==== hw/rvCtrlPkg.sv ====
`default_nettype none

package rvCtrlPkg;

	// Multicycle control states
	typedef enum logic [3:0] {
		fetch     = 4'd0,
		decode    = 4'd1,
		memAdr    = 4'd2,
		memRead   = 4'd3,
		memWb     = 4'd4,
		memWrite  = 4'd5,
		executeR  = 4'd6,
		executeI  = 4'd7,
		aluWb     = 4'd8,
		beqState  = 4'd9,
		jalState  = 4'd10
	} fsmStateT;

	// ALU operand A source
	typedef enum logic [1:0] {
		srcAPc    = 2'b00,
		srcAOldPc = 2'b01,
		srcAReg   = 2'b10
	} srcAT;

	typedef enum logic [1:0] {
		srcBReg  = 2'b00,
		srcBImm  = 2'b01,
		srcBFour = 2'b10 // PC increment
	} srcBT;

	// What drives the result bus
	typedef enum logic [1:0] {
		resAluOut    = 2'b00,
		resData      = 2'b01,
		resAluResult = 2'b10
	} resultSrcT;

endpackage

`default_nettype wire

// ==== hw/ctrlBus.sv ====
`timescale 1ns/1ps
`default_nettype none

interface ctrlBus;

	logic adrSrc; // High selects result over PC
	logic irWrite;
	logic pcUpdate;
	logic branch;
	rvCtrlPkg::srcAT aluSrcA;
	rvCtrlPkg::srcBT aluSrcB;
	rvCtrlPkg::resultSrcT resultSrc;
	rvIsaPkg::aluOpT aluControl;
	logic [rvIsaPkg::xlen-1:0] immExt;
	logic [rvIsaPkg::xlen-1:0] baseAddr; // rs1 read
	logic [rvIsaPkg::xlen-1:0] writeData; // rs2 read

	modport decode (
		output adrSrc, irWrite, pcUpdate, branch, aluSrcA, aluSrcB, resultSrc,
		output aluControl, immExt, baseAddr, writeData
	);

	modport datapath (
		input adrSrc, irWrite, pcUpdate, branch, aluSrcA, aluSrcB, resultSrc,
		input aluControl, immExt, baseAddr, writeData
	);

endinterface

`default_nettype wire

// ==== hw/controlFsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlFsm (
	input wire logic clk,
	input wire logic arstN,
	input wire rvIsaPkg::opcodeT opcode,
	ctrlBus.decode bus,
	output logic regWrite,
	output logic memWrite,
	output rvIsaPkg::aluClassT aluClass,
	output rvCtrlPkg::fsmStateT state
);

	rvCtrlPkg::fsmStateT nextState;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			state <= rvCtrlPkg::fetch;
		else
			state <= nextState;
	end

	always_comb begin
		nextState = rvCtrlPkg::fetch;
		case (state)
			rvCtrlPkg::fetch: nextState = rvCtrlPkg::decode;
			rvCtrlPkg::decode: begin
				case (opcode)
					rvIsaPkg::lwType, rvIsaPkg::sType: nextState = rvCtrlPkg::memAdr;
					rvIsaPkg::rType: nextState = rvCtrlPkg::executeR;
					rvIsaPkg::iType: nextState = rvCtrlPkg::executeI;
					rvIsaPkg::bType: nextState = rvCtrlPkg::beqState;
					rvIsaPkg::jType: nextState = rvCtrlPkg::jalState;
					default: nextState = rvCtrlPkg::fetch; // Unknown opcode dropped
				endcase
			end
			rvCtrlPkg::memAdr: begin
				if (opcode == rvIsaPkg::lwType)
					nextState = rvCtrlPkg::memRead;
				else
					nextState = rvCtrlPkg::memWrite;
			end
			rvCtrlPkg::memRead: nextState = rvCtrlPkg::memWb;
			rvCtrlPkg::executeR, rvCtrlPkg::executeI, rvCtrlPkg::jalState:
				nextState = rvCtrlPkg::aluWb;
			default: nextState = rvCtrlPkg::fetch;
		endcase
	end

	// Moore outputs default to idle
	always_comb begin
		bus.adrSrc = 1'b0;
		bus.irWrite = 1'b0;
		bus.pcUpdate = 1'b0;
		bus.branch = 1'b0;
		bus.aluSrcA = rvCtrlPkg::srcAPc;
		bus.aluSrcB = rvCtrlPkg::srcBFour;
		bus.resultSrc = rvCtrlPkg::resAluOut;
		regWrite = 1'b0;
		memWrite = 1'b0;
		aluClass = rvIsaPkg::classAdd;
		case (state)
			rvCtrlPkg::fetch: begin
				bus.irWrite = 1'b1;
				bus.pcUpdate = 1'b1; // PC <= PC + 4
				bus.resultSrc = rvCtrlPkg::resAluResult;
			end
			rvCtrlPkg::decode: begin // Branch and jump target into aluOut
				bus.aluSrcA = rvCtrlPkg::srcAOldPc;
				bus.aluSrcB = rvCtrlPkg::srcBImm;
			end
			rvCtrlPkg::memAdr: begin
				bus.aluSrcA = rvCtrlPkg::srcAReg;
				bus.aluSrcB = rvCtrlPkg::srcBImm;
			end
			rvCtrlPkg::memRead: bus.adrSrc = 1'b1;
			rvCtrlPkg::memWb: begin
				bus.resultSrc = rvCtrlPkg::resData;
				regWrite = 1'b1;
			end
			rvCtrlPkg::memWrite: begin
				bus.adrSrc = 1'b1;
				memWrite = 1'b1;
			end
			rvCtrlPkg::executeR: begin
				bus.aluSrcA = rvCtrlPkg::srcAReg;
				bus.aluSrcB = rvCtrlPkg::srcBReg;
				aluClass = rvIsaPkg::classFunct;
			end
			rvCtrlPkg::executeI: begin
				bus.aluSrcA = rvCtrlPkg::srcAReg;
				bus.aluSrcB = rvCtrlPkg::srcBImm;
				aluClass = rvIsaPkg::classFunct;
			end
			rvCtrlPkg::aluWb: regWrite = 1'b1;
			rvCtrlPkg::beqState: begin
				bus.aluSrcA = rvCtrlPkg::srcAReg;
				bus.aluSrcB = rvCtrlPkg::srcBReg;
				bus.branch = 1'b1;
				aluClass = rvIsaPkg::classSub;
			end
			rvCtrlPkg::jalState: begin // Jump to target and form old PC + 4 for rd
				bus.aluSrcA = rvCtrlPkg::srcAOldPc;
				bus.pcUpdate = 1'b1;
			end
			default: ;
		endcase
	end

	stateLegal: assert property (@(posedge clk) disable iff (!arstN)
		state inside {rvCtrlPkg::fetch, rvCtrlPkg::decode, rvCtrlPkg::memAdr,
			rvCtrlPkg::memRead, rvCtrlPkg::memWb, rvCtrlPkg::memWrite,
			rvCtrlPkg::executeR, rvCtrlPkg::executeI, rvCtrlPkg::aluWb,
			rvCtrlPkg::beqState, rvCtrlPkg::jalState});

	// A store lasts one cycle and is followed by a fresh fetch
	storeOnlyInWrite: assert property (@(posedge clk) disable iff (!arstN)
		memWrite |-> state == rvCtrlPkg::memWrite ##1 state == rvCtrlPkg::fetch);

endmodule

`default_nettype wire

// ==== hw/aluDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluDecoder (
	input wire rvIsaPkg::aluClassT aluClass,
	input wire logic [2:0] funct3,
	input wire logic funct7b5,
	input wire logic isRType,
	output rvIsaPkg::aluOpT aluControl
);

	always_comb begin
		case (aluClass)
			rvIsaPkg::classAdd: aluControl = rvIsaPkg::aluAdd;
			rvIsaPkg::classSub: aluControl = rvIsaPkg::aluSub;
			default: begin
				case (funct3)
					rvIsaPkg::f3AddSub: // addi never subtracts
						aluControl = (isRType && funct7b5) ? rvIsaPkg::aluSub : rvIsaPkg::aluAdd;
					rvIsaPkg::f3Slt: aluControl = rvIsaPkg::aluSlt;
					rvIsaPkg::f3Or: aluControl = rvIsaPkg::aluOr;
					rvIsaPkg::f3And: aluControl = rvIsaPkg::aluAnd;
					default: aluControl = rvIsaPkg::aluAdd;
				endcase
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/registerFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module registerFile (
	input wire logic clk,
	input wire logic arstN,
	input wire logic [rvIsaPkg::regAddrW-1:0] addr1,
	input wire logic [rvIsaPkg::regAddrW-1:0] addr2,
	input wire logic [rvIsaPkg::regAddrW-1:0] addr3, // Write address
	input wire logic regWrite,
	input wire logic [rvIsaPkg::xlen-1:0] dataIn,
	output logic [rvIsaPkg::xlen-1:0] rd1,
	output logic [rvIsaPkg::xlen-1:0] rd2
);

	logic [rvIsaPkg::xlen-1:0] regs [0:(1 << rvIsaPkg::regAddrW)-1];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < (1 << rvIsaPkg::regAddrW); i++)
				regs[i] <= '0;
		end else if (regWrite && addr3 != '0) begin
			regs[addr3] <= dataIn;
		end
	end

	assign rd1 = regs[addr1];
	assign rd2 = regs[addr2];

	x0Zero: assert property (@(posedge clk) regs[0] == '0);

endmodule

`default_nettype wire

// ==== hw/instructionDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module instructionDecode (
	input wire logic clk,
	input wire logic arstN,
	input wire logic [rvIsaPkg::xlen-1:0] instr,
	input wire logic [rvIsaPkg::xlen-1:0] resultData,
	ctrlBus.decode bus,
	output logic memWrite
);

	rvIsaPkg::opcodeT opcode;
	rvIsaPkg::aluClassT aluClass; // FSM to ALU decoder
	rvCtrlPkg::fsmStateT state;
	logic regWrite;
	logic [2:0] funct3;
	logic funct7b5;
	logic [rvIsaPkg::regAddrW-1:0] rd, rs1, rs2;

	assign opcode = rvIsaPkg::opcodeT'(instr[6:0]);

	// Function fields matter only for R and I types
	always_comb begin
		funct3 = 3'b000;
		funct7b5 = 1'b0;
		if (opcode == rvIsaPkg::rType || opcode == rvIsaPkg::iType) begin
			funct3 = instr[14:12];
			funct7b5 = instr[30];
		end
	end

	// Register fields by format
	always_comb begin
		rd = '0;
		rs1 = '0;
		rs2 = '0;
		case (opcode)
			rvIsaPkg::rType: begin
				rd = instr[11:7];
				rs1 = instr[19:15];
				rs2 = instr[24:20];
			end
			rvIsaPkg::iType, rvIsaPkg::lwType: begin
				rd = instr[11:7];
				rs1 = instr[19:15];
			end
			rvIsaPkg::sType, rvIsaPkg::bType: begin
				rs1 = instr[19:15];
				rs2 = instr[24:20]; // Store data or compare operand
			end
			rvIsaPkg::jType: rd = instr[11:7];
			default: ;
		endcase
	end

	always_comb begin
		case (opcode)
			rvIsaPkg::iType, rvIsaPkg::lwType: bus.immExt = {{20{instr[31]}}, instr[31:20]};
			rvIsaPkg::sType: bus.immExt = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			rvIsaPkg::bType:
				bus.immExt = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
			rvIsaPkg::jType:
				bus.immExt = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
			default: bus.immExt = '0;
		endcase
	end

	controlFsm instanceFsm (
		.clk(clk),
		.arstN(arstN),
		.opcode(opcode),
		.bus(bus),
		.regWrite(regWrite),
		.memWrite(memWrite),
		.aluClass(aluClass),
		.state(state)
	);

	aluDecoder instanceAluDec (
		.aluClass(aluClass),
		.funct3(funct3),
		.funct7b5(funct7b5),
		.isRType(opcode == rvIsaPkg::rType),
		.aluControl(bus.aluControl)
	);

	registerFile instanceRegFile (
		.clk(clk),
		.arstN(arstN),
		.addr1(rs1),
		.addr2(rs2),
		.addr3(rd),
		.regWrite(regWrite),
		.dataIn(resultData),
		.rd1(bus.baseAddr),
		.rd2(bus.writeData)
	);

	// Write-back closes the instruction
	regWriteThenFetch: assert property (@(posedge clk) disable iff (!arstN)
		regWrite |-> (state == rvCtrlPkg::memWb || state == rvCtrlPkg::aluWb)
			##1 state == rvCtrlPkg::fetch);

endmodule

`default_nettype wire

// ==== hw/execDatapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module execDatapath #(
	parameter logic [rvIsaPkg::xlen-1:0] resetPc = '0
) (
	input wire logic clk,
	input wire logic arstN,
	ctrlBus.datapath bus,
	input wire logic [rvIsaPkg::xlen-1:0] memReadData,
	output logic [rvIsaPkg::xlen-1:0] memAddr,
	output logic [rvIsaPkg::xlen-1:0] memWriteData,
	output logic [rvIsaPkg::xlen-1:0] instr,
	output logic [rvIsaPkg::xlen-1:0] result
);

	logic [rvIsaPkg::xlen-1:0] pc, oldPc, dataReg, aluOut;
	logic [rvIsaPkg::xlen-1:0] srcA, srcB, aluResult;
	logic zero;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			pc <= resetPc;
		else if (bus.pcUpdate || (bus.branch && zero))
			pc <= result;
	end

	always_ff @(posedge clk) begin
		if (bus.irWrite) begin
			oldPc <= pc; // PC of the fetched instruction
			instr <= memReadData;
		end
		dataReg <= memReadData;
		aluOut <= aluResult;
	end

	always_comb begin
		case (bus.aluSrcA)
			rvCtrlPkg::srcAOldPc: srcA = oldPc;
			rvCtrlPkg::srcAReg: srcA = bus.baseAddr;
			default: srcA = pc;
		endcase
		case (bus.aluSrcB)
			rvCtrlPkg::srcBReg: srcB = bus.writeData;
			rvCtrlPkg::srcBImm: srcB = bus.immExt;
			default: srcB = 32'd4;
		endcase
	end

	always_comb begin
		case (bus.aluControl)
			rvIsaPkg::aluSub: aluResult = srcA - srcB;
			rvIsaPkg::aluAnd: aluResult = srcA & srcB;
			rvIsaPkg::aluOr: aluResult = srcA | srcB;
			rvIsaPkg::aluSlt: aluResult = {31'b0, $signed(srcA) < $signed(srcB)};
			default: aluResult = srcA + srcB;
		endcase
	end

	assign zero = (aluResult == '0); // beq compares via subtraction

	always_comb begin
		case (bus.resultSrc)
			rvCtrlPkg::resData: result = dataReg;
			rvCtrlPkg::resAluResult: result = aluResult;
			default: result = aluOut;
		endcase
	end

	assign memAddr = bus.adrSrc ? result : pc;
	assign memWriteData = bus.writeData;

	// Fetch advances the PC by one word past the captured old PC
	fetchAdvance: assert property (@(posedge clk) disable iff (!arstN)
		bus.irWrite |=> pc == oldPc + 32'd4);

endmodule

`default_nettype wire

// ==== hw/riscvCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module riscvCore #(
	parameter logic [rvIsaPkg::xlen-1:0] resetPc = '0
) (
	input wire logic clk,
	input wire logic arstN,
	input wire logic [rvIsaPkg::xlen-1:0] memReadData,
	output logic [rvIsaPkg::xlen-1:0] memAddr,
	output logic [rvIsaPkg::xlen-1:0] memWriteData,
	output logic memWrite
);

	ctrlBus bus ();

	logic [rvIsaPkg::xlen-1:0] instr;
	logic [rvIsaPkg::xlen-1:0] result; // Write-back and next-PC value

	instructionDecode instanceDecode (
		.clk(clk),
		.arstN(arstN),
		.instr(instr),
		.resultData(result),
		.bus(bus),
		.memWrite(memWrite)
	);

	execDatapath #(
		.resetPc(resetPc)
	) instanceDatapath (
		.clk(clk),
		.arstN(arstN),
		.bus(bus),
		.memReadData(memReadData),
		.memAddr(memAddr),
		.memWriteData(memWriteData),
		.instr(instr),
		.result(result)
	);

endmodule

`default_nettype wire

// ==== verification/tbRiscvCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbRiscvCore;

	localparam logic [31:0] resetPc = 32'h0000_0010;
	localparam logic [31:0] dataBase = 32'h0000_0200; // Random operands
	localparam logic [31:0] resultBase = 32'h0000_0300; // One word per expected store
	localparam int clkPeriod = 4;
	localparam int resetCycles = 4;
	localparam int instrBudget = 60;
	localparam int timeoutNs = instrBudget * 5 * clkPeriod + 50 * clkPeriod;
	localparam int numTests = 6;
	localparam int maxStores = 32;

	logic clk;
	logic arstN;
	logic [31:0] memReadData;
	logic [31:0] memAddr;
	logic [31:0] memWriteData;
	logic memWrite;

	logic [31:0] mem [0:255];
	logic [31:0] expAddr [0:maxStores-1];
	logic [31:0] expData [0:maxStores-1];
	int expTest [0:maxStores-1]; // Owning test of each store
	int lastStore [0:numTests-1];
	int testErrors [0:numTests-1];
	string testNames [0:numTests-1];
	int numStores;
	int storeCount;
	int strayErrors;
	logic [31:0] progAddr;

	riscvCore #(
		.resetPc(resetPc)
	) u_dut (
		.clk(clk),
		.arstN(arstN),
		.memReadData(memReadData),
		.memAddr(memAddr),
		.memWriteData(memWriteData),
		.memWrite(memWrite)
	);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	// Shared instruction and data memory with combinational read
	assign memReadData = mem[memAddr[9:2]];

	always @(posedge clk) begin
		if (arstN && memWrite)
			mem[memAddr[9:2]] <= memWriteData;
	end

	always @(posedge clk or negedge arstN) begin
		if (!arstN)
			storeCount <= 0;
		else if (memWrite)
			storeCount <= storeCount + 1;
	end

	function automatic logic [31:0] sext12(input logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	function automatic logic [31:0] rFormat(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] iFormat(input logic [31:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm[11:0], rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] sFormat(input logic [31:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] bFormat(input logic [31:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] jFormat(input logic [31:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	task automatic emit(input logic [31:0] word);
		mem[progAddr[9:2]] = word;
		progAddr = progAddr + 32'd4;
	endtask

	// Store register rs2 to the next result slot and record what must arrive
	task automatic storeAt(input logic [4:0] rs2, input logic [31:0] value, input int test);
		logic [31:0] addr;
		addr = resultBase + 32'(4 * numStores);
		emit(sFormat(addr, rs2, 5'd0));
		expAddr[numStores] = addr;
		expData[numStores] = value;
		expTest[numStores] = test;
		lastStore[test] = numStores;
		numStores++;
	endtask

	task automatic loadProgram();
		logic [31:0] opA;
		logic [31:0] opB;
		logic [31:0] rtWord;
		logic [31:0] jalAddr;
		logic [11:0] imm [0:3];
		for (int i = 0; i < 256; i++)
			mem[i] = 32'hbad0_0000 | i;
		opA = $urandom();
		opB = $urandom();
		if (opB == opA)
			opB = ~opA; // Keeps the second beq not taken
		rtWord = $urandom();
		for (int k = 0; k < 4; k++)
			imm[k] = 12'($urandom());
		mem[dataBase[9:2]] = opA;
		mem[dataBase[9:2] + 8'd1] = opB;
		mem[dataBase[9:2] + 8'd2] = rtWord;
		progAddr = resetPc;
		numStores = 0;

		emit(iFormat(dataBase, 5'd0, 3'b010, 5'd1, 7'b0000011)); // lw x1
		emit(iFormat(dataBase + 32'd4, 5'd0, 3'b010, 5'd2, 7'b0000011)); // lw x2
		emit(rFormat(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
		storeAt(5'd3, opA + opB, 1);
		emit(rFormat(7'h20, 5'd2, 5'd1, 3'b000, 5'd3));
		storeAt(5'd3, opA - opB, 1);
		emit(rFormat(7'h00, 5'd2, 5'd1, 3'b111, 5'd3));
		storeAt(5'd3, opA & opB, 1);
		emit(rFormat(7'h00, 5'd2, 5'd1, 3'b110, 5'd3));
		storeAt(5'd3, opA | opB, 1);
		emit(rFormat(7'h00, 5'd2, 5'd1, 3'b010, 5'd3));
		storeAt(5'd3, {31'b0, $signed(opA) < $signed(opB)}, 1);
		emit(iFormat(sext12(imm[0]), 5'd1, 3'b000, 5'd3, 7'b0010011));
		storeAt(5'd3, opA + sext12(imm[0]), 1);
		emit(iFormat(sext12(imm[1]), 5'd1, 3'b111, 5'd3, 7'b0010011));
		storeAt(5'd3, opA & sext12(imm[1]), 1);
		emit(iFormat(sext12(imm[2]), 5'd1, 3'b110, 5'd3, 7'b0010011));
		storeAt(5'd3, opA | sext12(imm[2]), 1);
		emit(iFormat(sext12(imm[3]), 5'd1, 3'b010, 5'd3, 7'b0010011));
		storeAt(5'd3, {31'b0, $signed(opA) < $signed(sext12(imm[3]))}, 1);

		emit(iFormat(dataBase + 32'd8, 5'd0, 3'b010, 5'd4, 7'b0000011)); // lw x4
		storeAt(5'd4, rtWord, 2);

		emit(bFormat(32'd8, 5'd1, 5'd1)); // Taken
		emit(sFormat(32'h3f0, 5'd1, 5'd0)); // Must be skipped
		emit(bFormat(32'd8, 5'd2, 5'd1)); // Not taken
		storeAt(5'd2, opB, 3);

		jalAddr = progAddr;
		emit(jFormat(32'd8, 5'd5));
		emit(sFormat(32'h3f4, 5'd0, 5'd0)); // Jumped over
		storeAt(5'd5, jalAddr + 32'd4, 4);

		emit(iFormat(32'd5, 5'd1, 3'b000, 5'd0, 7'b0010011)); // addi x0
		storeAt(5'd0, 32'd0, 5);
		emit(jFormat(32'd0, 5'd0)); // Spin in place
	endtask

	task automatic reportStore(input int idx, input logic [31:0] addr, input logic [31:0] data);
		$display("ERROR %0t: store %0d wrote %h to %h, expected %h to %h", $time, idx, data,
			addr, expData[idx], expAddr[idx]);
		testErrors[expTest[idx]]++;
	endtask

	task automatic reportTest(input int t);
		$display("%-10s %s, %0d errors", testNames[t], testErrors[t] == 0 ? "ok" : "FAILED",
			testErrors[t]);
	endtask

	quietInReset: assert property (@(posedge clk) !arstN |-> !memWrite)
	else begin
		$display("ERROR %0t: memWrite high during reset", $time);
		testErrors[0]++;
	end

	fetchFromResetPc: assert property (@(posedge clk) $rose(arstN) |-> memAddr == resetPc)
	else begin
		$display("ERROR %0t: first fetch at %h, expected %h", $time, $sampled(memAddr), resetPc);
		testErrors[0]++;
	end

	storeMatches: assert property (@(posedge clk) disable iff (!arstN)
		memWrite && storeCount < numStores |->
			memAddr == expAddr[storeCount] && memWriteData == expData[storeCount])
	else reportStore($sampled(storeCount), $sampled(memAddr), $sampled(memWriteData));

	noExtraStore: assert property (@(posedge clk) disable iff (!arstN)
		memWrite |-> storeCount < numStores)
	else begin
		$display("ERROR %0t: store %0d to %h is beyond the program", $time,
			$sampled(storeCount), $sampled(memAddr));
		strayErrors++;
	end

	initial begin
		#(timeoutNs);
		$display("Watchdog expired before the program finished its stores");
		$display("test failed");
		$finish;
	end

	initial begin
		int totalErrors;
		int failingTests;
		arstN = 1'b0;
		strayErrors = 0;
		testNames[0] = "reset";
		testNames[1] = "arithmetic";
		testNames[2] = "roundTrip";
		testNames[3] = "branches";
		testNames[4] = "jal";
		testNames[5] = "x0";
		for (int t = 0; t < numTests; t++)
			testErrors[t] = 0;
		void'($urandom(32'hba0fa167));
		loadProgram();
		repeat (resetCycles) @(posedge clk);
		@(negedge clk) arstN = 1'b1;
		@(posedge clk);
		@(negedge clk);
		reportTest(0);
		for (int t = 1; t < numTests; t++) begin
			wait (storeCount > lastStore[t]);
			@(negedge clk);
			reportTest(t);
		end
		repeat (20) @(negedge clk); // Room for a stray store
		totalErrors = strayErrors;
		failingTests = 0;
		for (int t = 0; t < numTests; t++) begin
			totalErrors += testErrors[t];
			if (testErrors[t] != 0)
				failingTests++;
		end
		$display("%0d tests run, %0d with errors, %0d errors, %0d stray stores", numTests,
			failingTests, totalErrors, strayErrors);
		if (totalErrors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
hw/rvIsaPkg.sv
hw/rvCtrlPkg.sv
hw/ctrlBus.sv
hw/controlFsm.sv
hw/aluDecoder.sv
hw/registerFile.sv
hw/instructionDecode.sv
hw/execDatapath.sv
hw/riscvCore.sv
verification/tbRiscvCore.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tbRiscvCore
FILELIST ?= vlog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG ?= test passed
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG PASS_MSG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation PASS"; \
	else \
		echo "Simulation FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
